// File: bench/gemm_chk.sv
/*
 * Protocol checker bound into the matrix-tile multiply top level
 */
`timescale 1ns/1ps
`default_nettype none

module gemm_chk (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             z_valid_i,
  input logic             z_ready_i,
  input gemm_pkg::z_row_t z_data_i,
  input logic             z_last_i,
  input logic             x_ready_i,
  input logic             busy_i,
  input logic             done_i
);

  int fail_count = 0;

  // A stalled Z beat keeps its valid and its contents
  z_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (z_valid_i && !z_ready_i) |=> (z_valid_i && $stable(z_data_i) && $stable(z_last_i)))
    else begin
      fail_count++;
      $error("Z beat changed while stalled");
    end

  // Tile loading only happens inside a job
  x_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni) x_ready_i |-> busy_i)
    else begin
      fail_count++;
      $error("X ready high while idle");
    end

  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |=> !done_i)
    else begin
      fail_count++;
      $error("done held for more than one cycle");
    end

endmodule

bind gemm_top gemm_chk i_chk (
  .clk_i     ( clk_i     ),
  .rst_ni    ( rst_ni    ),
  .z_valid_i ( z_valid_o ),
  .z_ready_i ( z_ready_i ),
  .z_data_i  ( z_data_o  ),
  .z_last_i  ( z_last_o  ),
  .x_ready_i ( x_ready_o ),
  .busy_i    ( busy_o    ),
  .done_i    ( done_o    )
);

`default_nettype wire

// File: bench/gemm_tb.sv
/*
 * Testbench for the matrix-tile multiply unit
 * Directed jobs whose Z rows are checked against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

module gemm_tb;

  localparam int unsigned TestCount     = 5;
  localparam int unsigned CyclesPerTest = 2000;

  logic                           clk_i, rst_ni;
  logic                           x_valid_i, w_valid_i, y_valid_i, z_ready_i, start_i;
  logic                           x_ready_o, w_ready_o, y_ready_o, z_valid_o, z_last_o;
  logic                           busy_o, done_o;
  gemm_pkg::x_row_t               x_data_i;
  gemm_pkg::w_col_t               w_data_i;
  gemm_pkg::bias_row_t            y_data_i;
  gemm_pkg::z_row_t               z_data_o;
  logic [gemm_pkg::COL_CNT_W-1:0] n_cols_i;

  // Operands of the current job and the Z rows expected from them
  gemm_pkg::x_tile_t   x_tile;
  gemm_pkg::w_col_t    w_cols[$];
  gemm_pkg::bias_row_t y_rows[$];
  gemm_pkg::z_row_t    exp_z[$];
  int                  done_count = 0;

  gemm_top #(.FifoDepth(4)) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(negedge clk_i) begin
    if (done_o === 1'b1) done_count++;
  end

  initial begin
    repeat (TestCount * CyclesPerTest) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", TestCount * CyclesPerTest);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

  // Z[w] = Y[w] + sum over h of X[w][h] * W[h], truncated to the result width
  function automatic gemm_pkg::z_row_t model_z_row(input gemm_pkg::x_tile_t x,
                                                   input gemm_pkg::w_col_t wc,
                                                   input gemm_pkg::bias_row_t bias);
    gemm_pkg::z_row_t z;
    gemm_pkg::elem_t  xe, we, be;
    int               acc;
    for (int w = 0; w < gemm_pkg::ARRAY_W; w++) begin
      be  = bias[w];
      acc = int'(be);
      for (int h = 0; h < gemm_pkg::ARRAY_H; h++) begin
        xe  = x[w][h];
        we  = wc[h];
        acc = acc + int'(xe) * int'(we);
      end
      z[w] = gemm_pkg::acc_t'(acc);
    end
    return z;
  endfunction

  task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERROR @ %0t: %s mismatch, got %0h, expected %0h", $time, what, actual,
               expected);
      $display("test failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  task automatic apply_reset();
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_equal(busy_o, 1'b0, "busy after reset");
    check_equal(done_o, 1'b0, "done after reset");
    check_equal(x_ready_o, 1'b0, "X ready after reset");
    check_equal(z_valid_o, 1'b0, "Z valid after reset");
    check_equal(w_ready_o, 1'b1, "W ready after reset");
    check_equal(y_ready_o, 1'b1, "Y ready after reset");
    @(posedge clk_i);
  endtask

  task automatic send_x(input bit throttle, input int lead);
    repeat (lead) @(posedge clk_i);
    for (int r = 0; r < gemm_pkg::ARRAY_W; r++) begin
      while (throttle && $urandom % 3 == 0) begin
        x_valid_i <= 1'b0;
        @(posedge clk_i);
      end
      x_valid_i <= 1'b1;
      x_data_i  <= x_tile[r];
      @(negedge clk_i);
      while (!x_ready_o)
        @(negedge clk_i);
      @(posedge clk_i);
    end
    x_valid_i <= 1'b0;
  endtask

  task automatic send_w(input bit throttle);
    foreach (w_cols[i]) begin
      while (throttle && $urandom % 3 == 0) begin
        w_valid_i <= 1'b0;
        @(posedge clk_i);
      end
      w_valid_i <= 1'b1;
      w_data_i  <= w_cols[i];
      @(negedge clk_i);
      while (!w_ready_o)
        @(negedge clk_i);
      @(posedge clk_i);
    end
    w_valid_i <= 1'b0;
  endtask

  task automatic send_y(input bit throttle);
    foreach (y_rows[i]) begin
      while (throttle && $urandom % 3 == 0) begin
        y_valid_i <= 1'b0;
        @(posedge clk_i);
      end
      y_valid_i <= 1'b1;
      y_data_i  <= y_rows[i];
      @(negedge clk_i);
      while (!y_ready_o)
        @(negedge clk_i);
      @(posedge clk_i);
    end
    y_valid_i <= 1'b0;
  endtask

  // Takes exactly n rows in order, last only on the final one
  task automatic collect_z(input int n, input bit throttle);
    int got;
    got = 0;
    z_ready_i <= throttle ? 1'($urandom % 2) : 1'b1;
    while (got < n) begin
      @(negedge clk_i);
      if (z_valid_o && z_ready_i) begin
        check_equal(z_data_o, exp_z[got], "Z row");
        check_equal(z_last_o, got == n - 1, "Z last");
        got++;
      end
      @(posedge clk_i);
      z_ready_i <= (throttle && got < n) ? 1'($urandom % 2) : 1'b1;
    end
  endtask

  // Start request while the job is running, which the DUT must ignore
  task automatic stray_start();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_equal(busy_o, 1'b1, "busy during job");
    @(posedge clk_i);
    start_i  <= 1'b1;
    n_cols_i <= 8'd5;
    @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  task automatic run_job(input int n, input bit throttle, input bit z_throttle,
                         input int x_lead, input bit stray);
    exp_z.delete();
    for (int i = 0; i < n; i++)
      exp_z.push_back(model_z_row(x_tile, w_cols[i], y_rows[i]));
    start_i  <= 1'b1;
    n_cols_i <= gemm_pkg::COL_CNT_W'(n);
    @(posedge clk_i);
    start_i <= 1'b0;
    fork
      send_x(throttle, x_lead);
      send_w(throttle);
      send_y(throttle);
      collect_z(n, z_throttle);
      if (stray) stray_start();
    join
    @(negedge clk_i);
    check_equal(done_o, 1'b1, "done pulse");
    check_equal(busy_o, 1'b0, "busy after done");
    check_equal(z_valid_o, 1'b0, "Z valid after last row");
    @(negedge clk_i);
    check_equal(done_o, 1'b0, "done width");
    @(posedge clk_i);
  endtask

  task automatic random_operands(input int n);
    w_cols.delete();
    y_rows.delete();
    for (int r = 0; r < gemm_pkg::ARRAY_W; r++)
      x_tile[r] = gemm_pkg::x_row_t'($urandom);
    for (int i = 0; i < n; i++) begin
      w_cols.push_back(gemm_pkg::w_col_t'($urandom));
      y_rows.push_back(gemm_pkg::bias_row_t'($urandom));
    end
  endtask

  task automatic test_single_column();
    x_tile[0] = 32'h01020304;
    x_tile[1] = 32'hFFFEFDFC;
    x_tile[2] = 32'h7F8010F0;
    x_tile[3] = 32'h0005FB0A;
    w_cols    = '{32'h02FF0381};
    y_rows    = '{32'h10F07F80};
    run_job(1, 1'b0, 1'b0, 0, 1'b0);
  endtask

  task automatic test_eight_columns();
    random_operands(8);
    run_job(8, 1'b0, 1'b0, 0, 1'b0);
  endtask

  // Same operands as the previous job, Z side stalled at random
  task automatic test_z_backpressure();
    run_job(8, 1'b0, 1'b1, 0, 1'b0);
  endtask

  // W and Y stream in while the tile is still held back
  task automatic test_input_throttling();
    random_operands(6);
    run_job(6, 1'b1, 1'b0, 12, 1'b0);
  endtask

  task automatic test_back_to_back();
    int first_done;
    first_done = done_count;
    random_operands(3);
    run_job(3, 1'b0, 1'b0, 0, 1'b1);
    random_operands(3);
    run_job(3, 1'b0, 1'b0, 0, 1'b0);
    check_equal(done_count - first_done, 2, "done pulses over two jobs");
  endtask

  initial begin
    void'($urandom(48957));
    rst_ni    = 1'b0;
    x_valid_i = 1'b0;
    x_data_i  = '0;
    w_valid_i = 1'b0;
    w_data_i  = '0;
    y_valid_i = 1'b0;
    y_data_i  = '0;
    z_ready_i = 1'b0;
    start_i   = 1'b0;
    n_cols_i  = '0;
    apply_reset();
    test_single_column();
    test_eight_columns();
    test_z_backpressure();
    test_input_throttling();
    test_back_to_back();
    if (dut_i.i_chk.fail_count != 0) begin
      $display("test failed");
      $fatal(1, "the bound checker saw %0d assertion failures", dut_i.i_chk.fail_count);
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Verilator build and run of the matrix-tile multiply testbench
verilator --binary --timing --assert -Wno-fatal --top-module gemm_tb \
  -f verilog.f --Mdir obj_dir -o gemm_sim \
  && ./obj_dir/gemm_sim \
  || exit 1

// File: verilog.f
verilog/gemm_pkg.sv
verilog/operand_fifo.sv
verilog/x_tile_buffer.sv
verilog/tile_sequencer.sv
verilog/mac_array.sv
verilog/gemm_top.sv
bench/gemm_chk.sv
bench/gemm_tb.sv

// File: verilog/gemm_pkg.sv
/*
 * Matrix-tile multiply unit shared definitions
 * Array dimensions, element types and the packed beats between blocks
 */
`default_nettype none

package gemm_pkg;

  // Array shape, the packed types below are sized from these
  localparam int unsigned ARRAY_H = 4;
  localparam int unsigned ARRAY_W = 4;

  // Width of the per-job column count
  localparam int unsigned COL_CNT_W = 8;

  typedef logic signed [7:0]  elem_t;
  typedef logic signed [19:0] acc_t;

  typedef elem_t [ARRAY_H-1:0] x_row_t;
  typedef elem_t [ARRAY_H-1:0] w_col_t;
  typedef elem_t [ARRAY_W-1:0] bias_row_t;
  typedef x_row_t [ARRAY_W-1:0] x_tile_t;
  typedef acc_t [ARRAY_W-1:0] z_row_t;

  // One column operation handed from the sequencer to the array
  typedef struct packed {
    w_col_t    w_col;
    bias_row_t bias;
    logic      last;
  } mac_op_t;

  // Result row with end-of-job marker
  typedef struct packed {
    z_row_t z;
    logic   last;
  } z_beat_t;

endpackage

`default_nettype wire

// File: verilog/gemm_top.sv
/*
 * Matrix-tile multiply unit top level
 * X tile buffer, W and Y operand FIFOs, sequencer and MAC array
 */
`timescale 1ns/1ps
`default_nettype none

module gemm_top #(
  parameter int unsigned FifoDepth = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           x_valid_i,
  output logic                           x_ready_o,
  input  gemm_pkg::x_row_t               x_data_i,
  input  logic                           w_valid_i,
  output logic                           w_ready_o,
  input  gemm_pkg::w_col_t               w_data_i,
  input  logic                           y_valid_i,
  output logic                           y_ready_o,
  input  gemm_pkg::bias_row_t            y_data_i,
  output logic                           z_valid_o,
  input  logic                           z_ready_i,
  output gemm_pkg::z_row_t               z_data_o,
  output logic                           z_last_o,
  input  logic                           start_i,
  input  logic [gemm_pkg::COL_CNT_W-1:0] n_cols_i,
  output logic                           busy_o,
  output logic                           done_o
);

  gemm_pkg::x_tile_t   tile;
  logic                tile_full, arm, pop;
  logic                w_head_valid, y_head_valid;
  gemm_pkg::w_col_t    w_head;
  gemm_pkg::bias_row_t y_head;
  logic                op_valid, op_ready, retire_last;
  gemm_pkg::mac_op_t   op;
  gemm_pkg::z_beat_t   z_beat;

  x_tile_buffer i_x_buffer (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .arm_i       ( arm       ),
    .x_valid_i   ( x_valid_i ),
    .x_ready_o   ( x_ready_o ),
    .x_data_i    ( x_data_i  ),
    .tile_o      ( tile      ),
    .tile_full_o ( tile_full )
  );

  operand_fifo #(
    .FifoDepth ( FifoDepth          ),
    .payload_t ( gemm_pkg::w_col_t  )
  ) i_w_fifo (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .push_valid_i ( w_valid_i    ),
    .push_ready_o ( w_ready_o    ),
    .push_data_i  ( w_data_i     ),
    .pop_i        ( pop          ),
    .head_valid_o ( w_head_valid ),
    .head_data_o  ( w_head       )
  );

  operand_fifo #(
    .FifoDepth ( FifoDepth            ),
    .payload_t ( gemm_pkg::bias_row_t )
  ) i_y_fifo (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .push_valid_i ( y_valid_i    ),
    .push_ready_o ( y_ready_o    ),
    .push_data_i  ( y_data_i     ),
    .pop_i        ( pop          ),
    .head_valid_o ( y_head_valid ),
    .head_data_o  ( y_head       )
  );

  tile_sequencer i_sequencer (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .start_i        ( start_i      ),
    .n_cols_i       ( n_cols_i     ),
    .tile_full_i    ( tile_full    ),
    .w_head_valid_i ( w_head_valid ),
    .y_head_valid_i ( y_head_valid ),
    .w_head_i       ( w_head       ),
    .y_head_i       ( y_head       ),
    .op_ready_i     ( op_ready     ),
    .retire_last_i  ( retire_last  ),
    .pop_o          ( pop          ),
    .op_valid_o     ( op_valid     ),
    .op_o           ( op           ),
    .arm_o          ( arm          ),
    .busy_o         ( busy_o       ),
    .done_o         ( done_o       )
  );

  mac_array i_mac_array (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .tile_i        ( tile        ),
    .op_valid_i    ( op_valid    ),
    .op_ready_o    ( op_ready    ),
    .op_i          ( op          ),
    .z_valid_o     ( z_valid_o   ),
    .z_ready_i     ( z_ready_i   ),
    .z_o           ( z_beat      ),
    .retire_last_o ( retire_last )
  );

  assign z_data_o = z_beat.z;
  assign z_last_o = z_beat.last;

endmodule

`default_nettype wire

// File: verilog/mac_array.sv
/*
 * Integer multiply-accumulate array, products in stage 1 and row sums
 * with bias in the output stage, stalled as a whole by Z back-pressure
 */
`timescale 1ns/1ps
`default_nettype none

module mac_array (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  gemm_pkg::x_tile_t   tile_i,
  input  logic                op_valid_i,
  output logic                op_ready_o,
  input  gemm_pkg::mac_op_t   op_i,
  output logic                z_valid_o,
  input  logic                z_ready_i,
  output gemm_pkg::z_beat_t   z_o,
  output logic                retire_last_o
);

  localparam int unsigned W     = gemm_pkg::ARRAY_W;
  localparam int unsigned H     = gemm_pkg::ARRAY_H;
  localparam int unsigned ProdW = 2 * $bits(gemm_pkg::elem_t);

  logic signed [ProdW-1:0] prod_d  [W][H];
  logic signed [ProdW-1:0] s1_prod_q [W][H];
  gemm_pkg::bias_row_t     s1_bias_q;
  logic                    s1_valid_q, s1_last_q;
  gemm_pkg::z_beat_t       z_d, z_q;
  logic                    z_valid_q;
  logic                    advance;

  // A held output freezes every stage
  assign advance    = ~(z_valid_q & ~z_ready_i);
  assign op_ready_o = advance;

  always_comb begin
    for (int w = 0; w < W; w++) begin
      for (int h = 0; h < H; h++) begin
        prod_d[w][h] = $signed(tile_i[w][h]) * $signed(op_i.w_col[h]);
      end
    end
  end

  // Row sums start from the sign-extended bias
  always_comb begin
    gemm_pkg::acc_t acc;
    for (int w = 0; w < W; w++) begin
      acc = gemm_pkg::acc_t'(s1_bias_q[w]);
      for (int h = 0; h < H; h++) begin
        acc = acc + gemm_pkg::acc_t'(s1_prod_q[w][h]);
      end
      z_d.z[w] = acc;
    end
    z_d.last = s1_last_q;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      z_valid_q  <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= op_valid_i;
      z_valid_q  <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_prod_q <= prod_d;
      s1_bias_q <= op_i.bias;
      s1_last_q <= op_i.last;
      z_q       <= z_d;
    end
  end

  assign z_valid_o     = z_valid_q;
  assign z_o           = z_q;
  assign retire_last_o = z_valid_q & z_ready_i & z_q.last;

endmodule

`default_nettype wire

// File: verilog/operand_fifo.sv
/*
 * Operand FIFO with valid/ready push side and a head/pop read side
 * Payload type is a parameter so W columns and Y bias rows share it
 */
`timescale 1ns/1ps
`default_nettype none

module operand_fifo #(
  parameter int unsigned FifoDepth = 4,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_valid_i,
  output logic     push_ready_o,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output logic     head_valid_o,
  output payload_t head_data_o
);

  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  payload_t        mem_q [FifoDepth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push, pop;

  function automatic logic [PtrW-1:0] next_ptr(logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + PtrW'(1);
  endfunction

  assign push_ready_o = (count_q != CntW'(FifoDepth));
  assign head_valid_o = (count_q != '0);
  assign head_data_o  = mem_q[rd_ptr_q];

  assign push = push_valid_i & push_ready_o;
  // Popping an empty FIFO has no effect
  assign pop  = pop_i & head_valid_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + CntW'(1);
        2'b01:   count_q <= count_q - CntW'(1);
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_data_i;
  end

endmodule

`default_nettype wire

// File: verilog/tile_sequencer.sv
/*
 * Job sequencer, arms the tile load, issues one op per column from the
 * FIFO heads and closes the job once the last Z row has left
 */
`timescale 1ns/1ps
`default_nettype none

module tile_sequencer (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              start_i,
  input  logic [gemm_pkg::COL_CNT_W-1:0]    n_cols_i,
  input  logic                              tile_full_i,
  input  logic                              w_head_valid_i,
  input  logic                              y_head_valid_i,
  input  gemm_pkg::w_col_t                  w_head_i,
  input  gemm_pkg::bias_row_t               y_head_i,
  input  logic                              op_ready_i,
  input  logic                              retire_last_i,
  output logic                              pop_o,
  output logic                              op_valid_o,
  output gemm_pkg::mac_op_t                 op_o,
  output logic                              arm_o,
  output logic                              busy_o,
  output logic                              done_o
);

  localparam int unsigned CntW = gemm_pkg::COL_CNT_W;

  logic [CntW-1:0] cols_left_q;
  logic            busy_q, done_q;
  logic            start_ok, issue;

  // Start is ignored while a job runs or with an empty column count
  assign start_ok = start_i & ~busy_q & (n_cols_i != '0);
  assign arm_o    = start_ok;

  assign op_valid_o = busy_q & tile_full_i & w_head_valid_i & y_head_valid_i &
                      (cols_left_q != '0);
  assign issue      = op_valid_o & op_ready_i;
  assign pop_o      = issue;

  always_comb begin
    op_o.w_col = w_head_i;
    op_o.bias  = y_head_i;
    op_o.last  = (cols_left_q == CntW'(1));
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cols_left_q <= '0;
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      done_q <= retire_last_i;
      if (start_ok) begin
        cols_left_q <= n_cols_i;
        busy_q      <= 1'b1;
      end else begin
        if (issue) cols_left_q <= cols_left_q - CntW'(1);
        // Busy holds until the final row is taken downstream
        if (retire_last_i) busy_q <= 1'b0;
      end
    end
  end

  assign busy_o = busy_q;
  assign done_o = done_q;

endmodule

`default_nettype wire

// File: verilog/x_tile_buffer.sv
/*
 * X tile buffer, collects ARRAY_W rows after arming and holds the tile
 * until the next arm
 */
`timescale 1ns/1ps
`default_nettype none

module x_tile_buffer (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             arm_i,
  input  logic             x_valid_i,
  output logic             x_ready_o,
  input  gemm_pkg::x_row_t x_data_i,
  output gemm_pkg::x_tile_t tile_o,
  output logic             tile_full_o
);

  localparam int unsigned RowW = (gemm_pkg::ARRAY_W > 1) ? $clog2(gemm_pkg::ARRAY_W) : 1;

  logic [RowW-1:0]   row_q;
  logic              loading_q, full_q;
  gemm_pkg::x_tile_t tile_q;
  logic              x_fire;

  assign x_ready_o   = loading_q;
  assign x_fire      = x_valid_i & loading_q;
  assign tile_o      = tile_q;
  assign tile_full_o = full_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      row_q     <= '0;
      loading_q <= 1'b0;
      full_q    <= 1'b0;
    end else if (arm_i) begin
      row_q     <= '0;
      loading_q <= 1'b1;
      full_q    <= 1'b0;
    end else if (x_fire) begin
      if (row_q == RowW'(gemm_pkg::ARRAY_W - 1)) begin
        row_q     <= '0;
        loading_q <= 1'b0;
        full_q    <= 1'b1;
      end else begin
        row_q <= row_q + RowW'(1);
      end
    end
  end

  // Rows land in successive slots
  always_ff @(posedge clk_i) begin
    if (x_fire) tile_q[row_q] <= x_data_i;
  end

endmodule

`default_nettype wire
